/* all.f */
logic/i2c_pkg.sv
logic/i2c_byte_if.sv
logic/i2c_byte_engine.sv
logic/i2c_phase_ctrl.sv
logic/i2c_master.sv
test/i2c_mem_slave.sv
test/tb_i2c_master.sv

/* Makefile */
# Verilator build for the I2C master testbench

SIM := obj_dir/sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_i2c_master -f all.f -o sim

run: compile
	@out=$$(./$(SIM)); \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

/* test/tb_i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();

    logic        dri_clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        i2c_exec = 1'b0;
    logic        bit_ctrl = 1'b0;
    logic        i2c_rh_wl = 1'b0;
    addr_t       i2c_addr = '0;
    data_t       i2c_data_w = '0;
    data_t       i2c_data_r;
    logic        i2c_done;
    logic        scl;
    logic        sda_out;
    logic        sda_oe;
    logic        sda_in;
    logic        cmd_rd = 1'b0;
    logic        cmd_addr16 = 1'b0;
    logic        slave_err;
    int unsigned xfer_cnt;
    int unsigned done_cnt = 0;
    int unsigned issued = 0;
    data_t       model [addr_t];                    // expected memory contents

    always #2 dri_clk = ~dri_clk;

    i2c_master dut0 (
        .dri_clk(dri_clk), .rst_n(rst_n), .i2c_exec(i2c_exec), .bit_ctrl(bit_ctrl),
        .i2c_rh_wl(i2c_rh_wl), .i2c_addr(i2c_addr), .i2c_data_w(i2c_data_w),
        .i2c_data_r(i2c_data_r), .i2c_done(i2c_done), .scl(scl), .sda_out(sda_out),
        .sda_oe(sda_oe), .sda_in(sda_in)
    );

    i2c_mem_slave u_slave (
        .dri_clk(dri_clk), .rst_n(rst_n), .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe),
        .cmd_rd(cmd_rd), .cmd_addr16(cmd_addr16), .sda_in(sda_in), .err(slave_err),
        .xfer_cnt(xfer_cnt)
    );

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    function automatic addr_t mem_key(input logic a16, input addr_t a);
        return a16 ? a : {8'h00, a[7:0]};           // 8-bit commands reach the low page
    endfunction

    always @(posedge dri_clk) begin
        if (rst_n && i2c_done) done_cnt <= done_cnt + 1;
        if (slave_err) fail_stop("slave model saw a bus protocol error");
    end

    //******************************
    // bus idle and pulse checks
    //******************************
    assert property (@(posedge dri_clk) disable iff (!rst_n) i2c_done |-> (scl && sda_out))
        else fail_stop("bus not idle high at i2c_done");
    assert property (@(posedge dri_clk) disable iff (!rst_n) i2c_done |=> !i2c_done)
        else fail_stop("i2c_done longer than one cycle");

    task automatic start_cmd(input logic rd, input logic a16, input addr_t a, input data_t d);
        @(posedge dri_clk);
        i2c_exec   <= 1'b1;
        i2c_rh_wl  <= rd;
        bit_ctrl   <= a16;
        i2c_addr   <= a;
        i2c_data_w <= d;
        cmd_rd     <= rd;
        cmd_addr16 <= a16;
        issued++;
        @(posedge dri_clk);
        i2c_exec <= 1'b0;
    endtask

    task automatic check_counts();
        assert (done_cnt == issued) else
            fail_stop($sformatf("ERR t=%0t signal=done_cnt exp=%0d got=%0d",
                                $time, issued, done_cnt));
        assert (xfer_cnt == issued) else
            fail_stop($sformatf("ERR t=%0t signal=xfer_cnt exp=%0d got=%0d",
                                $time, issued, xfer_cnt));
    endtask

    task automatic wait_done();
        @(posedge dri_clk);
        while (!i2c_done) @(posedge dri_clk);
        @(negedge dri_clk);
        check_counts();
    endtask

    task automatic write_word(input logic a16, input addr_t a, input data_t d);
        start_cmd(1'b0, a16, a, d);
        wait_done();
        model[mem_key(a16, a)] = d;
    endtask

    task automatic read_word(input logic a16, input addr_t a);
        data_t exp;
        exp = model.exists(mem_key(a16, a)) ? model[mem_key(a16, a)] : 8'h00;
        start_cmd(1'b1, a16, a, data_t'($urandom));
        wait_done();
        assert (i2c_data_r == exp) else
            fail_stop($sformatf("ERR t=%0t signal=i2c_data_r exp=%h got=%h",
                                $time, exp, i2c_data_r));
    endtask

    // watchdog sized from the slowest command, a 16-bit read, times 38 commands
    initial begin : watchdog
        int unsigned worst;
        worst = 2 * (10 * bit_cycles) + 3 * (9 * bit_cycles) + stop_cycles + 8;
        repeat (40 * worst * 38) @(posedge dri_clk);
        fail_stop("timeout, the commands did not finish in time");
    end

    initial begin : stimulus
        addr_t a;
        addr_t a2;
        data_t d;
        logic  a16;
        void'($urandom(45));
        repeat (2) @(posedge dri_clk);
        rst_n <= 1'b1;
        @(negedge dri_clk);
        assert (scl && sda_out && sda_oe && !i2c_done && (i2c_data_r == 8'h00)) else
            fail_stop("outputs not at their reset levels");
        // 8-bit address round trips
        repeat (6) begin
            a = addr_t'($urandom);
            d = data_t'($urandom);
            write_word(1'b0, a, d);
            read_word(1'b0, a);
        end
        // 16-bit pairs differing only in the high byte
        repeat (4) begin
            a  = addr_t'($urandom);
            a2 = {~a[15:8], a[7:0]};
            write_word(1'b1, a, data_t'($urandom));
            write_word(1'b1, a2, data_t'($urandom));
            read_word(1'b1, a);
            read_word(1'b1, a2);
        end
        // mixed widths and directions
        repeat (8) begin
            a16 = 1'($urandom);
            a   = addr_t'($urandom);
            if (1'($urandom)) begin
                read_word(a16, a);
            end else begin
                write_word(a16, a, data_t'($urandom));
            end
        end
        // stray strobe in the middle of a write
        a = addr_t'($urandom);
        d = data_t'($urandom);
        start_cmd(1'b0, 1'b1, a, d);
        repeat (20) @(posedge dri_clk);
        i2c_exec   <= 1'b1;
        i2c_data_w <= ~d;
        @(posedge dri_clk);
        i2c_exec <= 1'b0;
        wait_done();
        model[a] = d;
        repeat (400) @(posedge dri_clk);
        @(negedge dri_clk);
        check_counts();
        read_word(1'b1, a);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* test/i2c_mem_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_mem_slave import i2c_pkg::*; (
    input  logic        dri_clk,
    input  logic        rst_n,
    input  logic        scl,
    input  logic        sda_out,
    input  logic        sda_oe,
    input  logic        cmd_rd,                     // command now on the bus is a read
    input  logic        cmd_addr16,                 // command now on the bus has 16-bit address
    output logic        sda_in,
    output logic        err,
    output int unsigned xfer_cnt                    // finished transfers, one per stop
);

    data_t       mem [addr_t];                      // sparse word memory
    logic        sda_line;                          // wired-and of master and slave
    logic        scl_q;
    logic        sda_q;
    logic        rise;
    logic        fall;
    logic        start_c;
    logic        stop_c;
    logic        in_xfer;
    logic        restarted;
    logic        tx_mode;                           // slave owns sda for data bits
    logic [3:0]  bit_cnt;                           // 0..7 data, 8 ack
    logic [3:0]  tx_left;
    int unsigned byte_idx;                          // byte number since last start
    data_t       shreg;
    data_t       tx_sr;
    addr_t       waddr;

    assign sda_line = sda_oe ? sda_out : sda_in;
    assign rise     = !scl_q && scl;
    assign fall     = scl_q && !scl;
    assign start_c  = scl_q && scl && sda_q && !sda_line;
    assign stop_c   = scl_q && scl && !sda_q && sda_line;

    function automatic data_t mem_read(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return 8'h00;                               // unwritten words read as zero
    endfunction

    //******************************
    // bus decode
    //******************************
    always @(posedge dri_clk or negedge rst_n) begin : decode
        data_t rx;
        if (!rst_n) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            sda_in    <= 1'b1;                      // released, pulled up
            err       <= 1'b0;
            xfer_cnt  <= 0;
            in_xfer   <= 1'b0;
            restarted <= 1'b0;
            tx_mode   <= 1'b0;
            bit_cnt   <= '0;
            tx_left   <= '0;
            byte_idx  <= 0;
            waddr     <= '0;
        end else begin
            scl_q <= scl;
            sda_q <= sda_line;
            rx    = {shreg[6:0], sda_line};
            if (scl_q && scl && (sda_q != sda_line)) begin
                // inside a transfer, a repeated start or a stop follows the first
                // scl rise after an ack slot
                assert (!in_xfer || (bit_cnt == 1)) else begin
                    $display("sda changed while scl high inside a byte at %0t", $time);
                    err <= 1'b1;
                end
            end
            if (start_c) begin
                if (in_xfer) begin
                    assert (cmd_rd && !restarted) else begin
                        $display("repeated start outside a read command at %0t", $time);
                        err <= 1'b1;
                    end
                    restarted <= 1'b1;
                end
                in_xfer  <= 1'b1;
                bit_cnt  <= '0;
                byte_idx <= 0;
                tx_mode  <= 1'b0;
            end else if (stop_c) begin
                assert (in_xfer) else begin
                    $display("stop condition with no transfer open at %0t", $time);
                    err <= 1'b1;
                end
                assert (restarted == cmd_rd) else begin
                    $display("ERR t=%0t signal=restarted exp=%0b got=%0b",
                             $time, cmd_rd, restarted);
                    err <= 1'b1;
                end
                in_xfer   <= 1'b0;
                restarted <= 1'b0;
                tx_mode   <= 1'b0;
                xfer_cnt  <= xfer_cnt + 1;
            end else if (rise && in_xfer) begin
                if (bit_cnt < 8) begin
                    shreg   <= rx;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 7) begin
                        if (byte_idx == 0) begin
                            assert (rx == {slave_addr, restarted}) else begin
                                $display("ERR t=%0t signal=addr_byte exp=%h got=%h",
                                         $time, {slave_addr, restarted}, rx);
                                err <= 1'b1;
                            end
                        end else if (!restarted) begin
                            if (cmd_addr16 && (byte_idx == 1)) begin
                                waddr[15:8] <= rx;  // high word address
                            end else if (byte_idx == (cmd_addr16 ? 2 : 1)) begin
                                waddr <= cmd_addr16 ? {waddr[15:8], rx} : {8'h00, rx};
                            end else if (byte_idx == (cmd_addr16 ? 3 : 2)) begin
                                mem[waddr] = rx;
                            end
                        end
                    end
                end else begin
                    // acknowledge slot
                    if (restarted && (byte_idx == 1)) begin
                        assert (sda_oe && sda_out) else begin
                            $display("no nack from master after read byte at %0t", $time);
                            err <= 1'b1;
                        end
                    end else begin
                        assert (!sda_oe) else begin
                            $display("master kept sda in an ack slot at %0t", $time);
                            err <= 1'b1;
                        end
                    end
                    bit_cnt  <= '0;
                    byte_idx <= byte_idx + 1;
                    if (restarted && (byte_idx == 0)) begin
                        tx_mode <= 1'b1;
                        tx_sr   <= mem_read(waddr);
                        tx_left <= 4'd8;
                    end
                end
            end
            if (fall && tx_mode) begin
                if (tx_left != 0) begin
                    sda_in  <= tx_sr[7];            // change only while scl low
                    tx_sr   <= {tx_sr[6:0], 1'b0};
                    tx_left <= tx_left - 1'b1;
                end else begin
                    sda_in <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master import i2c_pkg::*; (
    input  logic  dri_clk,
    input  logic  rst_n,

    // command side
    input  logic  i2c_exec,                         // one-cycle strobe
    input  logic  bit_ctrl,                         // 1 for 16-bit word address
    input  logic  i2c_rh_wl,                        // 1 read, 0 write
    input  addr_t i2c_addr,
    input  data_t i2c_data_w,
    output data_t i2c_data_r,
    output logic  i2c_done,

    // bus side, pad lives outside
    output logic  scl,
    output logic  sda_out,
    output logic  sda_oe,
    input  logic  sda_in
);

    i2c_byte_if byte_bus ();                        // one byte phase at a time

    //******************************
    // command sequencing
    //******************************
    i2c_phase_ctrl u_phase_ctrl (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .byte_bus   (byte_bus.ctrl)
    );

    //******************************
    // bus waveforms
    //******************************
    i2c_byte_engine u_byte_engine (
        .dri_clk  (dri_clk),
        .rst_n    (rst_n),
        .byte_bus (byte_bus.engine),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

`default_nettype wire

/* logic/i2c_phase_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_phase_ctrl import i2c_pkg::*; (
    input  logic     dri_clk,
    input  logic     rst_n,
    input  logic     i2c_exec,
    input  logic     bit_ctrl,
    input  logic     i2c_rh_wl,
    input  addr_t    i2c_addr,
    input  data_t    i2c_data_w,
    output data_t    i2c_data_r,
    output logic     i2c_done,
    i2c_byte_if.ctrl byte_bus
);

    state_t state;
    state_t next_state;
    logic   rd_cmd;                                 // 1 for a random read
    logic   addr16;                                 // 16-bit word address
    addr_t  addr_q;
    data_t  data_q;
    logic   accept;
    logic   issue;                                  // entering a bus state
    phase_t next_phase;
    data_t  next_tx;

    assign accept = (state == st_idle) && i2c_exec;

    //******************************
    // phase sequence
    //******************************
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (i2c_exec) next_state = st_sladdr;
            end
            st_sladdr: begin
                if (byte_bus.done) next_state = addr16 ? st_addr_hi : st_addr_lo;
            end
            st_addr_hi: begin
                if (byte_bus.done) next_state = st_addr_lo;
            end
            st_addr_lo: begin
                if (byte_bus.done) next_state = rd_cmd ? st_addr_rd : st_data_wr;
            end
            st_data_wr: begin
                if (byte_bus.done) next_state = st_stop;
            end
            st_addr_rd: begin
                if (byte_bus.done) next_state = st_data_rd;
            end
            st_data_rd: begin
                if (byte_bus.done) next_state = st_stop;
            end
            st_stop: begin
                if (byte_bus.done) next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    assign issue = (next_state != state) && (next_state != st_idle);

    // what the engine runs for each state
    always_comb begin
        next_phase = ph_write;
        next_tx    = '0;
        case (next_state)
            st_sladdr:  next_phase = ph_start_addr;
            st_addr_hi: next_tx    = addr_q[15:8];
            st_addr_lo: next_tx    = addr_q[7:0];
            st_data_wr: next_tx    = data_q;
            st_addr_rd: next_phase = ph_restart_addr;
            st_data_rd: next_phase = ph_read;
            st_stop:    next_phase = ph_stop;
            default: ;
        endcase
    end

    //******************************
    // state and handshake registers
    //******************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= st_idle;
            rd_cmd         <= 1'b0;
            addr16         <= 1'b0;
            byte_bus.go    <= 1'b0;
            byte_bus.phase <= ph_stop;
            i2c_done       <= 1'b0;
            i2c_data_r     <= '0;
        end else begin
            state       <= next_state;
            byte_bus.go <= issue;                   // one cycle after exec or done
            i2c_done    <= (state == st_stop) && byte_bus.done;
            if (issue) begin
                byte_bus.phase <= next_phase;
            end
            if (accept) begin
                rd_cmd <= i2c_rh_wl;
                addr16 <= bit_ctrl;
            end
            if ((state == st_data_rd) && byte_bus.done) begin
                i2c_data_r <= byte_bus.rx_byte;     // held until the next read
            end
        end
    end

    // command payload
    always_ff @(posedge dri_clk) begin
        if (accept) begin
            addr_q <= i2c_addr;
            data_q <= i2c_data_w;
        end
        if (issue) begin
            byte_bus.tx_byte <= next_tx;
        end
    end

endmodule

`default_nettype wire

/* logic/i2c_byte_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_engine import i2c_pkg::*; (
    input  logic       dri_clk,
    input  logic       rst_n,
    i2c_byte_if.engine byte_bus,
    output logic       scl,
    output logic       sda_out,
    output logic       sda_oe,
    input  logic       sda_in
);

    logic       busy;                               // phase running
    cnt_t       cnt;                                // cycle within the phase
    phase_t     cur_phase;                          // phase captured at go
    cnt_t       last_cnt;
    logic [1:0] sub;                                // cycle within the bit
    logic       is_addr;
    logic       in_start;
    logic       ack_slot;
    logic       data_bit;
    logic       phase_end;
    data_t      tx_sr;                              // outgoing bits, msb first
    data_t      rx_sr;                              // incoming bits

    //******************************
    // phase decode
    //******************************
    always_comb begin
        case (cur_phase)
            ph_start_addr, ph_restart_addr: last_cnt = cnt_t'(addr_cycles - 1);
            ph_stop:                        last_cnt = cnt_t'(stop_cycles - 1);
            default:                        last_cnt = cnt_t'(byte_cycles - 1);
        endcase
    end

    assign is_addr  = (cur_phase == ph_start_addr) || (cur_phase == ph_restart_addr);
    // start bit is one bit long so bit boundaries stay aligned to cnt
    assign sub      = 2'(cnt % bit_cycles);
    assign in_start = is_addr && (cnt < cnt_t'(bit_cycles));
    assign ack_slot = (cur_phase != ph_stop) && (cnt > last_cnt - cnt_t'(bit_cycles));
    assign data_bit = busy && !in_start && !ack_slot && (cur_phase != ph_stop);

    assign phase_end        = busy && (cnt == last_cnt);
    assign byte_bus.done    = phase_end;
    assign byte_bus.rx_byte = rx_sr;

    //******************************
    // cycle counter and bus lines
    //******************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cnt       <= '0;
            cur_phase <= ph_stop;
            scl       <= 1'b1;                      // bus idles high
            sda_out   <= 1'b1;
            sda_oe    <= 1'b1;
        end else if (!busy) begin
            if (byte_bus.go) begin
                busy      <= 1'b1;
                cnt       <= '0;
                cur_phase <= byte_bus.phase;
            end
        end else begin
            cnt  <= phase_end ? '0 : cnt + 1'b1;
            busy <= !phase_end;
            if (cur_phase == ph_stop) begin
                case (cnt)
                    cnt_t'(0): begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;            // low while scl low
                    end
                    cnt_t'(1): scl     <= 1'b1;
                    cnt_t'(3): sda_out <= 1'b1;     // stop, sda rises with scl high
                    default: ;
                endcase
            end else if (in_start) begin
                case (sub)
                    2'd0: begin
                        sda_oe  <= 1'b1;            // take sda back after an ack
                        sda_out <= 1'b1;
                    end
                    2'd1:    scl     <= 1'b1;
                    2'd2:    sda_out <= 1'b0;       // start or repeated start
                    default: scl     <= 1'b0;
                endcase
            end else begin
                case (sub)
                    2'd0: begin
                        if (ack_slot) begin
                            sda_oe  <= (cur_phase == ph_read); // nack after a read byte
                            sda_out <= 1'b1;
                        end else if (cur_phase == ph_read) begin
                            sda_oe  <= 1'b0;        // slave drives data
                        end else begin
                            sda_oe  <= 1'b1;
                            sda_out <= tx_sr[7];
                        end
                    end
                    2'd1:                 scl <= 1'b1;
                    2'(bit_cycles - 1):   scl <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    //******************************
    // shift registers
    //******************************
    always_ff @(posedge dri_clk) begin
        if (!busy && byte_bus.go) begin
            case (byte_bus.phase)
                ph_start_addr:   tx_sr <= {slave_addr, 1'b0};
                ph_restart_addr: tx_sr <= {slave_addr, 1'b1};
                default:         tx_sr <= byte_bus.tx_byte;
            endcase
        end else if (data_bit) begin
            if (sub == 2'd0) begin
                tx_sr <= {tx_sr[6:0], 1'b0};        // next bit to the top
            end
            if ((sub == 2'd1) && (cur_phase == ph_read)) begin
                rx_sr <= {rx_sr[6:0], sda_in};      // sample as scl rises
            end
        end
    end

endmodule

`default_nettype wire

/* logic/i2c_byte_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface i2c_byte_if import i2c_pkg::*; ();

    logic   go;                                     // one-cycle phase start
    phase_t phase;                                  // sampled with go
    data_t  tx_byte;                                // sampled with go
    data_t  rx_byte;                                // valid with done
    logic   done;                                   // last cycle of the phase

    // controller side issues phases
    modport ctrl (
        output go, phase, tx_byte,
        input  rx_byte, done
    );

    // engine side runs them on the bus
    modport engine (
        input  go, phase, tx_byte,
        output rx_byte, done
    );

endinterface

`default_nettype wire

/* logic/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

    //******************************
    // bus constants
    //******************************
    localparam logic [6:0]  slave_addr  = 7'b1010000;          // memory device address
    localparam int unsigned bit_cycles  = 4;                   // dri_clk cycles per bus bit
    localparam int unsigned stop_cycles = 17;                  // length of the stop phase

    // eight data bits plus the acknowledge slot
    localparam int unsigned byte_cycles = 9 * bit_cycles;
    // start bit in front of the address byte
    localparam int unsigned addr_cycles = byte_cycles + bit_cycles;
    localparam int unsigned cnt_w       = $clog2(addr_cycles); // phase cycle counter width

    //******************************
    // data types
    //******************************
    typedef logic [15:0]      addr_t;                          // word address
    typedef logic [7:0]       data_t;                          // data byte
    typedef logic [cnt_w-1:0] cnt_t;

    typedef enum logic [2:0] {
        ph_start_addr,                                         // start, address + write
        ph_restart_addr,                                       // repeated start, address + read
        ph_write,                                              // byte out, slave acks
        ph_read,                                               // byte in, master nacks
        ph_stop
    } phase_t;

    // one-hot command states
    typedef enum logic [7:0] {
        st_idle    = 8'b0000_0001,
        st_sladdr  = 8'b0000_0010,
        st_addr_hi = 8'b0000_0100,
        st_addr_lo = 8'b0000_1000,
        st_data_wr = 8'b0001_0000,
        st_addr_rd = 8'b0010_0000,
        st_data_rd = 8'b0100_0000,
        st_stop    = 8'b1000_0000
    } state_t;

endpackage

`default_nettype wire
